/* Bender.yml */
package:
  name: udp_rx

sources:
  - src/udp_rx_pkg.sv
  - src/rx_meta_if.sv
  - src/udp_rx.sv
  - src/eth_fcs_check.sv
  - src/rx_pkt_status.sv
  - src/udp_rx_top.sv
  - target: test
    files:
      - test/tb_udp_rx.sv

/* sim.f */
src/udp_rx_pkg.sv
src/rx_meta_if.sv
src/udp_rx.sv
src/eth_fcs_check.sv
src/rx_pkt_status.sv
src/udp_rx_top.sv
test/tb_udp_rx.sv

/* src/eth_fcs_check.sv */
module eth_fcs_check import udp_rx_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       gmii_rx_dv,
    input  gmii_byte_t gmii_rxd,
    output logic       frame_end,
    output logic       fcs_ok
);

    logic in_frame;   // sfd seen, dv still high
    logic pre_run;    // nothing but preamble bytes so far in this burst
    crc_t crc;

    // one byte through the reflected crc, lsb first
    function automatic crc_t crc_byte(input crc_t crc_in, input gmii_byte_t data);
        crc_t c;
        c = crc_in;
        for (int i = 0; i < 8; i++) begin
            if (c[0] ^ data[i])
                c = (c >> 1) ^ CRC_POLY;
            else
                c = c >> 1;
        end
        return c;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_frame  <= 1'b0;
            pre_run   <= 1'b1;
            crc       <= CRC_INIT;
            frame_end <= 1'b0;
            fcs_ok    <= 1'b0;
        end
        else begin
            frame_end <= 1'b0;
            if (!gmii_rx_dv) begin
                pre_run <= 1'b1;                // rearm for the next burst
                if (in_frame) begin
                    frame_end <= 1'b1;
                    fcs_ok    <= (crc == CRC_RESIDUE);
                    in_frame  <= 1'b0;
                    crc       <= CRC_INIT;
                end
            end
            else if (in_frame) begin
                crc <= crc_byte(crc, gmii_rxd);  // fcs bytes included
            end
            else begin
                pre_run <= pre_run && (gmii_rxd == PREAMBLE_BYTE);
                if (pre_run && (gmii_rxd == SFD_BYTE))
                    in_frame <= 1'b1;
            end
        end
    end

endmodule

/* src/rx_meta_if.sv */
interface rx_meta_if import udp_rx_pkg::*; ();

    logic      pkt_done;   // one cycle, payload fully received
    byte_cnt_t byte_num;   // udp payload length
    ip_addr_t  src_ip;
    udp_port_t src_port;
    udp_port_t dst_port;

    // fields hold from one pkt_done to the next
    modport parser (
        output pkt_done,
        output byte_num,
        output src_ip,
        output src_port,
        output dst_port
    );

    modport status (
        input pkt_done,
        input byte_num,
        input src_ip,
        input src_port,
        input dst_port
    );

endinterface

/* src/rx_pkt_status.sv */
module rx_pkt_status import udp_rx_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    rx_meta_if.status meta,
    input  logic      frame_end,
    input  logic      fcs_ok,
    output logic      rec_pkt_done,
    output logic      rec_fcs_ok,
    output byte_cnt_t rec_byte_num,
    output ip_addr_t  rec_src_ip,
    output udp_port_t rec_src_port,
    output udp_port_t rec_dst_port
);

    logic      pending;   // parser result waiting for its fcs verdict
    logic      release_now;
    byte_cnt_t pend_byte_num;
    ip_addr_t  pend_src_ip;
    udp_port_t pend_src_port;
    udp_port_t pend_dst_port;

    assign release_now = frame_end && pending;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending      <= 1'b0;
            rec_pkt_done <= 1'b0;
            rec_fcs_ok   <= 1'b0;
        end
        else begin
            rec_pkt_done <= release_now;
            if (release_now)
                rec_fcs_ok <= fcs_ok;
            // every frame end drops the pending result
            if (meta.pkt_done)
                pending <= 1'b1;
            else if (frame_end)
                pending <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (meta.pkt_done) begin
            pend_byte_num <= meta.byte_num;
            pend_src_ip   <= meta.src_ip;
            pend_src_port <= meta.src_port;
            pend_dst_port <= meta.dst_port;
        end
        if (release_now) begin
            rec_byte_num <= pend_byte_num;
            rec_src_ip   <= pend_src_ip;
            rec_src_port <= pend_src_port;
            rec_dst_port <= pend_dst_port;
        end
    end

endmodule

/* src/udp_rx.sv */
module udp_rx import udp_rx_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       gmii_rx_dv,
    input  gmii_byte_t gmii_rxd,
    output logic       rec_en,
    output rx_word_t   rec_data,
    rx_meta_if.parser  meta
);

    rx_state_t   state;
    rx_state_t   next_state;
    byte_cnt_t   cnt;           // bytes taken since entering the current state
    mac_addr_t   dst_mac;
    gmii_byte_t  eth_type_hi;
    byte_cnt_t   ip_hdr_last;   // index of the last ip header byte
    logic [23:0] dst_ip_hi;     // first three bytes of the destination ip
    ip_addr_t    src_ip;
    udp_port_t   src_port;
    udp_port_t   dst_port;
    byte_cnt_t   udp_len;
    byte_cnt_t   pay_len;
    logic        mac_ok;
    logic        last_byte;
    logic        pkt_end;

    assign pay_len   = udp_len - UDP_HDR_BYTES;
    assign mac_ok    = (dst_mac == BOARD_MAC) || (dst_mac == BCAST_MAC);
    assign last_byte = (cnt == pay_len - 16'd1);

    // last payload byte, or a datagram carrying no payload at all
    assign pkt_end = gmii_rx_dv &&
                     (((state == rx_data) && last_byte) ||
                      ((state == udp_head) && (cnt == 16'd7) && (udp_len == UDP_HDR_BYTES)));

    // **************************************************
    // state machine
    // **************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            state <= idle;
        else
            state <= next_state;
    end

    always_comb begin
        next_state = state;
        case (state)
            idle: begin
                if (gmii_rx_dv)
                    next_state = (gmii_rxd == PREAMBLE_BYTE) ? preamble : rx_end;
            end
            preamble: begin
                if (!gmii_rx_dv)
                    next_state = idle;
                else if (cnt < 16'd6) begin   // six more preamble bytes
                    if (gmii_rxd != PREAMBLE_BYTE)
                        next_state = rx_end;
                end
                else
                    next_state = (gmii_rxd == SFD_BYTE) ? eth_head : rx_end;
            end
            eth_head: begin
                if (!gmii_rx_dv)
                    next_state = idle;
                else if (cnt == 16'd13) begin
                    if (mac_ok && ({eth_type_hi, gmii_rxd} == ETH_TYPE_IP))
                        next_state = ip_head;
                    else
                        next_state = rx_end;
                end
            end
            ip_head: begin
                if (!gmii_rx_dv)
                    next_state = idle;
                else if (cnt == 16'd0) begin
                    if (gmii_rxd[3:0] < 4'd5)   // ihl too short to hold the addresses
                        next_state = rx_end;
                end
                else if ((cnt == 16'd19) && ({dst_ip_hi, gmii_rxd} != BOARD_IP))
                    next_state = rx_end;
                else if (cnt == ip_hdr_last)
                    next_state = udp_head;
            end
            udp_head: begin
                if (!gmii_rx_dv)
                    next_state = idle;
                else if (cnt == 16'd7)
                    next_state = (udp_len > UDP_HDR_BYTES) ? rx_data : rx_end;
            end
            rx_data: begin
                if (!gmii_rx_dv)
                    next_state = idle;      // truncated frame, no report
                else if (last_byte)
                    next_state = rx_end;
            end
            rx_end: begin
                if (!gmii_rx_dv)
                    next_state = idle;
            end
            default: next_state = idle;
        endcase
    end

    // **************************************************
    // counter and strobes
    // **************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt           <= '0;
            rec_en        <= 1'b0;
            meta.pkt_done <= 1'b0;
        end
        else begin
            if (next_state != state)
                cnt <= '0;
            else if (gmii_rx_dv)
                cnt <= cnt + 16'd1;
            // full word, or the partial word at the end
            rec_en <= gmii_rx_dv && (state == rx_data) && ((cnt[1:0] == 2'd3) || last_byte);
            meta.pkt_done <= pkt_end;
        end
    end

    // **************************************************
    // header capture and payload packing
    // **************************************************
    always_ff @(posedge clk) begin
        if (gmii_rx_dv) begin
            case (state)
                eth_head: begin
                    if (cnt < 16'd6)
                        dst_mac <= {dst_mac[39:0], gmii_rxd};
                    if (cnt == 16'd12)
                        eth_type_hi <= gmii_rxd;
                end
                ip_head: begin
                    if (cnt == 16'd0)
                        ip_hdr_last <= {10'd0, gmii_rxd[3:0], 2'b00} - 16'd1;
                    if ((cnt >= 16'd12) && (cnt <= 16'd15))
                        src_ip <= {src_ip[23:0], gmii_rxd};
                    if ((cnt >= 16'd16) && (cnt <= 16'd18))
                        dst_ip_hi <= {dst_ip_hi[15:0], gmii_rxd};
                end
                udp_head: begin
                    if (cnt <= 16'd1)
                        src_port <= {src_port[7:0], gmii_rxd};
                    else if (cnt <= 16'd3)
                        dst_port <= {dst_port[7:0], gmii_rxd};
                    else if (cnt <= 16'd5)
                        udp_len <= {udp_len[7:0], gmii_rxd};
                end
                rx_data: begin
                    // lower lanes are zeroed as each byte lands
                    case (cnt[1:0])
                        2'd0: rec_data        <= {gmii_rxd, 24'd0};
                        2'd1: rec_data[23:0]  <= {gmii_rxd, 16'd0};
                        2'd2: rec_data[15:0]  <= {gmii_rxd, 8'd0};
                        2'd3: rec_data[7:0]   <= gmii_rxd;
                        default: ;
                    endcase
                end
                default: ;
            endcase
        end

        if (pkt_end) begin
            meta.byte_num <= pay_len;
            meta.src_ip   <= src_ip;
            meta.src_port <= src_port;
            meta.dst_port <= dst_port;
        end
    end

endmodule

/* src/udp_rx_pkg.sv */
package udp_rx_pkg;

    // **************************************************
    // field widths
    // **************************************************
    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;
    typedef logic [15:0] byte_cnt_t;
    typedef logic [31:0] rx_word_t;    // first payload byte in [31:24]
    typedef logic [7:0]  gmii_byte_t;
    typedef logic [31:0] crc_t;

    // **************************************************
    // board addresses and protocol constants
    // **************************************************
    localparam mac_addr_t BOARD_MAC = 48'h00_0a_35_01_fe_c0;
    localparam ip_addr_t  BOARD_IP  = {8'd192, 8'd168, 8'd1, 8'd123};
    localparam mac_addr_t BCAST_MAC = 48'hff_ff_ff_ff_ff_ff;

    localparam logic [15:0] ETH_TYPE_IP   = 16'h0800;
    localparam gmii_byte_t  PREAMBLE_BYTE = 8'h55;
    localparam gmii_byte_t  SFD_BYTE      = 8'hd5;
    localparam byte_cnt_t   UDP_HDR_BYTES = 16'd8;

    // reflected crc-32 as used by the ethernet fcs
    localparam crc_t CRC_POLY    = 32'hedb8_8320;
    localparam crc_t CRC_INIT    = 32'hffff_ffff;
    localparam crc_t CRC_RESIDUE = 32'hdebb_20e3;  // register value after a good fcs

    // parser states
    typedef enum logic [2:0] {
        idle,
        preamble,
        eth_head,
        ip_head,
        udp_head,
        rx_data,
        rx_end
    } rx_state_t;

endpackage

/* src/udp_rx_top.sv */
module udp_rx_top import udp_rx_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       gmii_rx_dv,
    input  gmii_byte_t gmii_rxd,
    output logic       rec_en,
    output rx_word_t   rec_data,
    output logic       rec_pkt_done,
    output logic       rec_fcs_ok,
    output byte_cnt_t  rec_byte_num,
    output ip_addr_t   rec_src_ip,
    output udp_port_t  rec_src_port,
    output udp_port_t  rec_dst_port
);

    logic frame_end;
    logic fcs_ok;

    rx_meta_if meta_bus ();

    // header parser and payload packer
    udp_rx u_udp_rx (
        .clk        (clk),
        .rst_n      (rst_n),
        .gmii_rx_dv (gmii_rx_dv),
        .gmii_rxd   (gmii_rxd),
        .rec_en     (rec_en),
        .rec_data   (rec_data),
        .meta       (meta_bus.parser)
    );

    // fcs check on the same byte stream
    eth_fcs_check u_eth_fcs_check (
        .clk        (clk),
        .rst_n      (rst_n),
        .gmii_rx_dv (gmii_rx_dv),
        .gmii_rxd   (gmii_rxd),
        .frame_end  (frame_end),
        .fcs_ok     (fcs_ok)
    );

    rx_pkt_status u_rx_pkt_status (
        .clk          (clk),
        .rst_n        (rst_n),
        .meta         (meta_bus.status),
        .frame_end    (frame_end),
        .fcs_ok       (fcs_ok),
        .rec_pkt_done (rec_pkt_done),
        .rec_fcs_ok   (rec_fcs_ok),
        .rec_byte_num (rec_byte_num),
        .rec_src_ip   (rec_src_ip),
        .rec_src_port (rec_src_port),
        .rec_dst_port (rec_dst_port)
    );

endmodule

/* test/tb_udp_rx.sv */
module tb_udp_rx;

    localparam int MAX_CASES  = 32;
    localparam int CLK_PERIOD = 10;

    logic        clk;
    logic        rst_n;
    logic        gmii_rx_dv;
    logic [7:0]  gmii_rxd;
    logic        rec_en;
    logic [31:0] rec_data;
    logic        rec_pkt_done;
    logic        rec_fcs_ok;
    logic [15:0] rec_byte_num;
    logic [31:0] rec_src_ip;
    logic [15:0] rec_src_port;
    logic [15:0] rec_dst_port;

    // **************************************************
    // case table and scoreboard
    // **************************************************
    string       c_name  [MAX_CASES];
    logic [47:0] c_mac   [MAX_CASES];
    logic [15:0] c_type  [MAX_CASES];
    logic [31:0] c_dip   [MAX_CASES];
    int          c_ihl   [MAX_CASES];
    logic [31:0] c_sip   [MAX_CASES];
    logic [15:0] c_sport [MAX_CASES];
    logic [15:0] c_dport [MAX_CASES];
    int          c_len   [MAX_CASES];
    int          c_bad   [MAX_CASES];   // 1 flips an fcs bit, 2 breaks the preamble
    int          c_acc   [MAX_CASES];
    int          c_gap   [MAX_CASES];   // idle cycles after the frame
    int          n_cases;

    logic [7:0]  frame_q[$];
    logic [31:0] exp_word_q[$];
    string       word_name_q[$];
    string       rep_name_q[$];
    logic [15:0] rep_len_q[$];
    logic [31:0] rep_ip_q[$];
    logic [15:0] rep_sport_q[$];
    logic [15:0] rep_dport_q[$];
    logic        rep_fcs_q[$];

    int          errors;
    int          checks;
    int          since_fall;    // monitor cycles since dv last fell
    logic        dv_prev;
    string       mon_name;
    logic [31:0] lcg_state;
    logic        limit_ready;
    longint      limit_time;
    longint      total_cycles;

    udp_rx_top u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .gmii_rx_dv   (gmii_rx_dv),
        .gmii_rxd     (gmii_rxd),
        .rec_en       (rec_en),
        .rec_data     (rec_data),
        .rec_pkt_done (rec_pkt_done),
        .rec_fcs_ok   (rec_fcs_ok),
        .rec_byte_num (rec_byte_num),
        .rec_src_ip   (rec_src_ip),
        .rec_src_port (rec_src_port),
        .rec_dst_port (rec_dst_port)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [7:0] lcg_byte();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[23:16];
    endfunction

    // one byte into the reflected ethernet crc
    function automatic logic [31:0] crc_step(input logic [31:0] r, input logic [7:0] b);
        logic [31:0] x;
        x = r ^ {24'd0, b};
        for (int i = 0; i < 8; i++)
            x = x[0] ? ((x >> 1) ^ 32'hedb8_8320) : (x >> 1);
        return x;
    endfunction

    function automatic int frame_len(input int ihl, input int len);
        return 8 + 14 + 4 * ihl + 8 + len + 4;
    endfunction

    task automatic check_value(input string tname, input string field,
                               input logic [47:0] expected, input logic [47:0] actual);
        checks++;
        if (expected !== actual) begin
            $display("FAIL %s %s: expected %0h, actual %0h", tname, field, expected, actual);
            errors++;
        end
    endtask

    task automatic push_bytes(input logic [47:0] value, input int n);
        for (int i = n - 1; i >= 0; i--)
            frame_q.push_back(value[8*i +: 8]);   // network order, msb first
    endtask

    task automatic read_cases();
        int    fd;
        int    n;
        string line;
        fd = $fopen("test/udp_rx_cases.txt", "r");
        if (fd == 0) begin
            $display("ERROR: cannot open test/udp_rx_cases.txt");
            errors++;
            return;
        end
        while (!$feof(fd) && n_cases < MAX_CASES) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#")
                continue;
            n = $sscanf(line, "%s %h %h %h %d %h %h %h %d %d %d %d",
                        c_name[n_cases], c_mac[n_cases], c_type[n_cases], c_dip[n_cases],
                        c_ihl[n_cases], c_sip[n_cases], c_sport[n_cases], c_dport[n_cases],
                        c_len[n_cases], c_bad[n_cases], c_acc[n_cases], c_gap[n_cases]);
            if (n == 12)
                n_cases++;
            else begin
                $display("ERROR: malformed case line: %s", line);
                errors++;
            end
        end
        $fclose(fd);
    endtask

    // **************************************************
    // frame builder, fills frame_q and the expectations
    // **************************************************
    task automatic build_frame(input int k);
        logic [7:0]  pay[$];
        logic [31:0] crc;
        logic [31:0] word;
        int          hdr_len;
        frame_q.delete();
        hdr_len = 4 * c_ihl[k];
        for (int i = 0; i < c_len[k]; i++)
            pay.push_back(lcg_byte());
        push_bytes(48'h5555_5555_5555, 6);
        push_bytes(8'h55, 1);
        push_bytes(8'hd5, 1);
        if (c_bad[k] == 2)
            frame_q[2] = 8'h54;
        push_bytes(c_mac[k], 6);
        push_bytes(48'h02_00_00_00_00_01, 6);   // source mac
        push_bytes(c_type[k], 2);
        push_bytes(8'h40 + c_ihl[k], 1);
        push_bytes(8'h00, 1);
        push_bytes(hdr_len + 8 + c_len[k], 2);  // ip total length
        push_bytes(32'h0000_4000, 4);
        push_bytes(16'h4011, 2);                // ttl 64, udp
        push_bytes(16'h0000, 2);
        push_bytes(c_sip[k], 4);
        push_bytes(c_dip[k], 4);
        for (int i = 20; i < hdr_len; i++)
            push_bytes(8'h01, 1);               // nop options
        push_bytes(c_sport[k], 2);
        push_bytes(c_dport[k], 2);
        push_bytes(8 + c_len[k], 2);
        push_bytes(16'h0000, 2);
        foreach (pay[i])
            frame_q.push_back(pay[i]);
        crc = 32'hffff_ffff;
        for (int i = 8; i < frame_q.size(); i++)
            crc = crc_step(crc, frame_q[i]);
        crc = ~crc;
        if (c_bad[k] == 1)
            crc[0] = ~crc[0];
        for (int i = 0; i < 4; i++)
            frame_q.push_back(crc[8*i +: 8]);   // fcs goes out lsb first
        if (c_acc[k] != 0) begin
            for (int i = 0; i < c_len[k]; i += 4) begin
                word = '0;
                for (int j = 0; j < 4; j++)
                    if (i + j < c_len[k])
                        word[31 - 8*j -: 8] = pay[i + j];
                exp_word_q.push_back(word);
                word_name_q.push_back(c_name[k]);
            end
            rep_name_q.push_back(c_name[k]);
            rep_len_q.push_back(c_len[k]);
            rep_ip_q.push_back(c_sip[k]);
            rep_sport_q.push_back(c_sport[k]);
            rep_dport_q.push_back(c_dport[k]);
            rep_fcs_q.push_back(c_bad[k] != 1);
        end
    endtask

    task automatic drive_frame(input int gap);
        foreach (frame_q[i]) begin
            @(posedge clk);
            gmii_rx_dv <= 1'b1;
            gmii_rxd   <= frame_q[i];
        end
        @(posedge clk);
        gmii_rx_dv <= 1'b0;
        gmii_rxd   <= 8'h00;
        repeat (gap - 1) @(posedge clk);
    endtask

    // **************************************************
    // monitor, samples on the falling edge
    // **************************************************
    always @(negedge clk) begin
        if (!rst_n) begin
            since_fall = 0;
            dv_prev    = 1'b0;
        end
        else begin
            since_fall = (dv_prev && !gmii_rx_dv) ? 1 : since_fall + 1;
            dv_prev    = gmii_rx_dv;
            if (rec_en) begin
                if (exp_word_q.size() == 0) begin
                    $display("ERROR: rec_en pulsed with no payload word expected");
                    errors++;
                end
                else
                    check_value(word_name_q.pop_front(), "rec_data",
                                exp_word_q.pop_front(), rec_data);
            end
            if (rec_pkt_done) begin
                if (rep_name_q.size() == 0) begin
                    $display("ERROR: rec_pkt_done pulsed for a frame that should be dropped");
                    errors++;
                end
                else begin
                    mon_name = rep_name_q.pop_front();
                    check_value(mon_name, "rec_byte_num", rep_len_q.pop_front(), rec_byte_num);
                    check_value(mon_name, "rec_src_ip", rep_ip_q.pop_front(), rec_src_ip);
                    check_value(mon_name, "rec_src_port", rep_sport_q.pop_front(), rec_src_port);
                    check_value(mon_name, "rec_dst_port", rep_dport_q.pop_front(), rec_dst_port);
                    check_value(mon_name, "rec_fcs_ok", rep_fcs_q.pop_front(), rec_fcs_ok);
                    check_value(mon_name, "report latency", 3, since_fall);  // 2 after dv falls
                end
            end
        end
    end

    initial begin
        wait (limit_ready);
        #(limit_time);
        $display("ERROR: watchdog expired, the simulation hung");
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        rst_n       = 1'b0;
        gmii_rx_dv  = 1'b0;
        gmii_rxd    = 8'h00;
        errors      = 0;
        checks      = 0;
        n_cases     = 0;
        lcg_state   = 32'd64764;
        limit_ready = 1'b0;
        read_cases();
        if (n_cases == 0) begin
            $display("ERROR: no test cases were read");
            errors++;
        end
        total_cycles = 4 + 20;
        for (int k = 0; k < n_cases; k++)
            total_cycles += frame_len(c_ihl[k], c_len[k]) + c_gap[k];
        limit_time  = total_cycles * CLK_PERIOD + 1000;
        limit_ready = 1'b1;

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        for (int k = 0; k < n_cases; k++) begin
            build_frame(k);
            drive_frame(c_gap[k]);
        end
        repeat (4) @(posedge clk);

        if (exp_word_q.size() != 0) begin
            $display("ERROR: %0d payload words never arrived", exp_word_q.size());
            errors++;
        end
        if (rep_name_q.size() != 0) begin
            $display("ERROR: %0d packet reports never arrived", rep_name_q.size());
            errors++;
        end
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

/* test/udp_rx_cases.txt */
# name dst_mac eth_type dst_ip ihl src_ip src_port dst_port pay_len corrupt accept gap
# corrupt: 0 none, 1 flip one fcs bit, 2 break the preamble; gap in idle cycles
unicast_16     000a3501fec0 0800 c0a8017b 5 c0a80102 1f90 1388 16 0 1 12
bcast_8        ffffffffffff 0800 c0a8017b 5 c0a80103 0401 0402 8  0 1 12
ip_options     000a3501fec0 0800 c0a8017b 7 0a000001 c350 0050 12 0 1 12
bad_mac        000a3501fec1 0800 c0a8017b 5 c0a80104 1000 2000 16 0 0 12
after_bad_mac  000a3501fec0 0800 c0a8017b 5 c0a80105 1001 2001 4  0 1 12
bad_ethertype  000a3501fec0 0806 c0a8017b 5 c0a80106 1002 2002 8  0 0 12
bad_dst_ip     000a3501fec0 0800 c0a8017c 5 c0a80107 1003 2003 8  0 0 12
after_bad_ip   ffffffffffff 0800 c0a8017b 5 c0a80108 1004 2004 8  0 1 12
bad_preamble   000a3501fec0 0800 c0a8017b 5 c0a80109 1005 2005 8  2 0 12
after_bad_pre  000a3501fec0 0800 c0a8017b 5 c0a8010a 1006 2006 12 0 1 12
len_one        000a3501fec0 0800 c0a8017b 5 c0a8010b 1007 2007 1  0 1 12
len_mod1       000a3501fec0 0800 c0a8017b 5 c0a8010c 1008 2008 5  0 1 12
len_mod2       000a3501fec0 0800 c0a8017b 6 c0a8010d 1009 2009 6  0 1 12
len_mod3       000a3501fec0 0800 c0a8017b 5 c0a8010e 100a 200a 7  0 1 12
bad_fcs        000a3501fec0 0800 c0a8017b 5 c0a8010f 100b 200b 20 1 1 12
b2b_first      000a3501fec0 0800 c0a8017b 5 0a000002 3000 4000 9  0 1 2
b2b_second     ffffffffffff 0800 c0a8017b 5 0a000003 3001 4001 14 0 1 2
b2b_third      000a3501fec0 0800 c0a8017b 5 0a000004 3002 4002 3  0 1 12
